//--- sources.f
src/prefetch_pkg.sv
src/fetch_head_if.sv
src/fetch_fsm.sv
src/addr_queue.sv
src/rdata_queue.sv
src/instr_aligner.sv
src/prefetch_buffer.sv
sim/imem_model.sv
sim/tb_prefetch_buffer.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f --top-module tb_prefetch_buffer -Mdir obj_dir &&
./obj_dir/Vtb_prefetch_buffer || { echo "build or simulation failed"; exit 1; }

//--- sim/tb_prefetch_buffer.sv
// self-checking testbench, memory image repeats every 2 KB and the run stops at the first error
module tb_prefetch_buffer;
  import prefetch_pkg::*;

  logic  clk;
  logic  rst_n;
  logic  req;
  logic  branch;
  addr_t branch_addr;
  logic  ready;
  logic  valid;
  word_t rdata;
  addr_t addr;
  logic  instr_req;
  addr_t instr_addr;
  logic  instr_gnt;
  logic  instr_rvalid;
  word_t instr_rdata;
  logic  busy;

  // reference model and monitor state
  addr_t exp_addr;
  logic  outstanding;
  logic  branched;
  logic  held;
  addr_t held_addr;
  word_t held_data;
  int    xfer_cnt;
  string test_name;

  prefetch_buffer prefetch_buffer_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req),
    .branch_i       (branch),
    .branch_addr_i  (branch_addr),
    .ready_i        (ready),
    .valid_o        (valid),
    .rdata_o        (rdata),
    .addr_o         (addr),
    .instr_req_o    (instr_req),
    .instr_addr_o   (instr_addr),
    .instr_gnt_i    (instr_gnt),
    .instr_rvalid_i (instr_rvalid),
    .instr_rdata_i  (instr_rdata),
    .busy_o         (busy)
  );

  imem_model imem_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (instr_req),
    .addr_i   (instr_addr),
    .gnt_o    (instr_gnt),
    .rvalid_o (instr_rvalid),
    .rdata_o  (instr_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    assert (actual === expected) else begin
      fail_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // per-cycle checks sampled mid-cycle after the inputs have settled
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_cycle();
    half_t low_half;
    half_t high_half;
    low_half  = imem_i.half_at(exp_addr);
    high_half = imem_i.half_at(exp_addr + addr_t'(HALF_BYTES));
    // quiet until the core redirects
    if (!branched && !branch) begin
      assert (!valid && !instr_req && !busy) else begin
        fail_run("valid_o, instr_req_o or busy_o went high before the first branch");
      end
    end
    // raised request or granted access still out
    if (instr_req || outstanding) begin
      assert (busy) else fail_run("busy_o is low while a memory access is pending");
    end
    // stalled output holds and its upper parcel only counts for a 32-bit instruction
    if (held) begin
      assert (valid) else fail_run("valid_o dropped while ready_i was low");
      check_value({test_name, " held addr_o"}, held_addr, addr);
      if (held_data[1:0] == UNCOMPRESSED_OP) begin
        check_value({test_name, " held rdata_o"}, held_data, rdata);
      end else begin
        check_value({test_name, " held rdata_o[15:0]"}, word_t'(held_data[15:0]),
                    word_t'(rdata[15:0]));
      end
    end
    // transfer against the parcel stream
    if (valid && ready) begin
      check_value({test_name, " addr_o"}, exp_addr, addr);
      if (low_half[1:0] == UNCOMPRESSED_OP) begin
        check_value({test_name, " rdata_o"}, {high_half, low_half}, rdata);
        exp_addr = exp_addr + addr_t'(WORD_BYTES);
      end else begin
        check_value({test_name, " rdata_o[15:0]"}, word_t'(low_half), word_t'(rdata[15:0]));
        exp_addr = exp_addr + addr_t'(HALF_BYTES);
      end
      xfer_cnt++;
    end
    held      = valid && !ready && !branch;
    held_addr = addr;
    held_data = rdata;
    // new stream starts at the target
    if (branch) begin
      // memory sees the target in the redirect cycle
      check_value({test_name, " instr_addr_o"}, branch_addr, instr_addr);
      branched = 1'b1;
      exp_addr = branch_addr;
    end
    outstanding = (outstanding && !instr_rvalid) || (instr_req && instr_gnt);
  endtask

  initial begin
    forever begin
      @(negedge clk);
      #2;
      if (rst_n) begin
        check_cycle();
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_cycle(input logic rand_ready);
    @(negedge clk);
    branch = 1'b0;
    ready  = rand_ready ? ($urandom_range(1, 0) == 1) : 1'b1;
  endtask

  // core stalls in the redirect cycle
  task automatic do_branch(input addr_t target);
    @(negedge clk);
    req         = 1'b1;
    branch      = 1'b1;
    branch_addr = target;
    ready       = 1'b0;
  endtask

  task automatic branch_on_pending(input addr_t target, input logic rand_ready);
    bit found;
    found = 1'b0;
    for (int cyc = 0; cyc < 60 && !found; cyc++) begin
      @(negedge clk);
      if (outstanding && !instr_rvalid) begin
        found       = 1'b1;
        branch      = 1'b1;
        branch_addr = target;
        ready       = 1'b0;
      end else begin
        branch = 1'b0;
        ready  = rand_ready ? ($urandom_range(1, 0) == 1) : 1'b1;
      end
    end
    if (!found) begin
      fail_run("timeout waiting for a memory response to be outstanding");
    end
  endtask

  task automatic wait_transfers(input int count, input logic rand_ready);
    int  first_cnt;
    int  limit;
    bit  done;
    first_cnt = xfer_cnt;
    limit     = count * 40 + 100;
    done      = 1'b0;
    for (int cyc = 0; cyc < limit && !done; cyc++) begin
      drive_cycle(rand_ready);
      done = (xfer_cnt - first_cnt) >= count;
    end
    if (!done) begin
      fail_run($sformatf("timeout after %0d cycles waiting for %0d transfers", limit, count));
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    req         = 1'b0;
    branch      = 1'b0;
    branch_addr = '0;
    ready       = 1'b0;
    exp_addr    = '0;
    outstanding = 1'b0;
    branched    = 1'b0;
    held        = 1'b0;
    xfer_cnt    = 0;
    test_name   = "reset";
    void'($urandom(32'h209));
    imem_i.fill_random(40);
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    test_name = "idle after reset";
    repeat (10) drive_cycle(1'b0);

    test_name = "aligned stream";
    do_branch(32'h0000_0100);
    wait_transfers(400, 1'b0);

    // target on the upper parcel of a word
    test_name = "unaligned target";
    do_branch(32'h0000_02a6);
    wait_transfers(200, 1'b0);

    test_name = "branch over pending";
    for (int i = 0; i < 6; i++) begin
      branch_on_pending($urandom & 32'h0000_fffe, 1'b0);
      wait_transfers(20, 1'b0);
    end

    test_name = "random ready";
    do_branch(32'h0000_0046);
    wait_transfers(400, 1'b1);
    for (int i = 0; i < 6; i++) begin
      branch_on_pending($urandom & 32'h0000_fffe, 1'b1);
      wait_transfers(30, 1'b1);
    end

    $display("All tests passed");
    $finish;
  end

endmodule

//--- sim/imem_model.sv
// one access outstanding at a time, only address bits 10:1 select a parcel so the 2 KB image repeats
module imem_model (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_i,
  input  prefetch_pkg::addr_t addr_i,
  output logic                gnt_o,
  output logic                rvalid_o,
  output prefetch_pkg::word_t rdata_o
);
  import prefetch_pkg::*;

  // halfword image, lower parcel of a word at the lower address
  half_t       mem [1024];
  logic        outstanding;
  int unsigned gnt_wait;
  int unsigned rv_wait;
  addr_t       addr_q;

  // response ends the access, a new grant may come in the same cycle
  assign rvalid_o = outstanding && (rv_wait == 0);
  assign rdata_o  = {mem[{addr_q[10:2], 1'b1}], mem[{addr_q[10:2], 1'b0}]};
  assign gnt_o    = req_i && (!outstanding || rvalid_o) && (gnt_wait == 0);

  // random parcels, a share of them forced to the 32-bit opcode
  task automatic fill_random(input int uncompressed_pct);
    for (int i = 0; i < 1024; i++) begin
      mem[i[9:0]] = half_t'($urandom);
      if ($urandom_range(99, 0) < uncompressed_pct) begin
        mem[i[9:0]][1:0] = UNCOMPRESSED_OP;
      end
    end
  endtask

  // parcel at a byte address, used by the reference model
  function automatic half_t half_at(input addr_t addr);
    return mem[addr[10:1]];
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= 1'b0;
      gnt_wait    <= 0;
      rv_wait     <= 0;
      addr_q      <= '0;
    end else begin
      if (rvalid_o) begin
        outstanding <= 1'b0;
      end else if (outstanding) begin
        rv_wait <= rv_wait - 1;
      end
      // grant latches the address, rvalid follows 1 to 3 cycles later
      if (gnt_o) begin
        outstanding <= 1'b1;
        addr_q      <= addr_i;
        rv_wait     <= $urandom_range(2, 0);
        gnt_wait    <= $urandom_range(3, 0);
      end else if (req_i && (gnt_wait > 0) && (!outstanding || rvalid_o)) begin
        gnt_wait <= gnt_wait - 1;
      end
    end
  end

endmodule

//--- src/prefetch_buffer.sv
// req_i must stay high while fetching, a branch also needs no req_i
module prefetch_buffer (
  input  logic                clk,
  input  logic                rst_n,

  // core side
  input  logic                req_i,
  input  logic                branch_i,
  input  prefetch_pkg::addr_t branch_addr_i,
  input  logic                ready_i,
  output logic                valid_o,
  output prefetch_pkg::word_t rdata_o,
  output prefetch_pkg::addr_t addr_o,

  // instruction memory side
  output logic                instr_req_o,
  output prefetch_pkg::addr_t instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  prefetch_pkg::word_t instr_rdata_i,

  // status
  output logic                busy_o
);

  // fsm to queue strobes
  logic addr_push;
  logic data_push;
  logic wait_gnt;
  logic addr_ready;

  // queue heads shared with the aligner
  fetch_head_if head_if ();

  ////////////////////////////////////////////////////////////////////////////
  // memory side
  ////////////////////////////////////////////////////////////////////////////

  fetch_fsm fetch_fsm_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_i),
    .addr_ready_i   (addr_ready),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_req_o    (instr_req_o),
    .addr_push_o    (addr_push),
    .data_push_o    (data_push),
    .wait_gnt_o     (wait_gnt),
    .busy_o         (busy_o)
  );

  // fetch address doubles as the memory address
  addr_queue addr_queue_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .push_i        (addr_push),
    .wait_gnt_i    (wait_gnt),
    .ready_o       (addr_ready),
    .fetch_addr_o  (instr_addr_o),
    .head          (head_if.addr_side)
  );

  rdata_queue rdata_queue_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .branch_i (branch_i),
    .push_i   (data_push),
    .rdata_i  (instr_rdata_i),
    .head     (head_if.data_side)
  );

  ////////////////////////////////////////////////////////////////////////////
  // core side
  ////////////////////////////////////////////////////////////////////////////

  instr_aligner instr_aligner_i (
    .ready_i (ready_i),
    .valid_o (valid_o),
    .rdata_o (rdata_o),
    .addr_o  (addr_o),
    .head    (head_if.aligner)
  );

endmodule

//--- src/instr_aligner.sv
// upper half of rdata_o is not meaningful for a compressed instruction
module instr_aligner (
  input  logic                ready_i,
  output logic                valid_o,
  output prefetch_pkg::word_t rdata_o,
  output prefetch_pkg::addr_t addr_o,
  fetch_head_if.aligner       head
);
  import prefetch_pkg::*;

  word_t head_word, next_word;
  logic  head_ok, next_ok;
  half_t upper_half;
  logic  aligned_rvc, unaligned_rvc;
  logic  unaligned;
  logic  xfer;

  ////////////////////////////////////////////////////////////////////////////
  // head words, queued or bypassed
  ////////////////////////////////////////////////////////////////////////////

  assign head_word = head.head_data_valid[0] ? head.head_data[0] : head.in_data;
  assign head_ok   = head.head_data_valid[0] || (head.head_addr_valid[0] && head.in_push);
  // incoming word lands in entry 1 when entry 0 already holds data
  assign next_word = head.head_data_valid[1] ? head.head_data[1] : head.in_data;
  assign next_ok   = head.head_data_valid[1] ||
                     (head.head_data_valid[0] && head.head_addr_valid[1] && head.in_push);

  assign upper_half    = head_word[31:16];
  assign aligned_rvc   = head_word[1:0] != UNCOMPRESSED_OP;
  assign unaligned_rvc = upper_half[1:0] != UNCOMPRESSED_OP;
  assign unaligned     = head.head_addr[0][1];

  // address was queued at request time, so it is always ready first
  assign addr_o = head.head_addr[0];

  always_comb begin
    if (unaligned) begin
      // upper half of the head joined with the lower half of the next word
      rdata_o = {next_word[15:0], upper_half};
      valid_o = unaligned_rvc ? head_ok : (head_ok && next_ok);
    end else begin
      rdata_o = head_word;
      valid_o = head_ok;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // queue advance on transfer
  ////////////////////////////////////////////////////////////////////////////

  assign xfer = valid_o && ready_i;

  // aligned compressed stays in the same word
  assign head.half_step = xfer && !unaligned && aligned_rvc;
  // everything else is done with the head word
  assign head.pop       = xfer && (unaligned || !aligned_rvc);
  // only an unaligned 32-bit instruction leaves its tail in the next word
  assign head.next_half = unaligned && !unaligned_rvc;

endmodule

//--- src/rdata_queue.sv
// returned words in fetch order, never holds more entries than the address queue
module rdata_queue (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                branch_i,
  input  logic                push_i,
  input  prefetch_pkg::word_t rdata_i,
  fetch_head_if.data_side     head
);
  import prefetch_pkg::*;

  word_t [FETCH_DEPTH-1:0] data_q, data_int, data_n;
  logic  [FETCH_DEPTH-1:0] valid_q, valid_int, valid_n;

  assign head.head_data       = data_q[1:0];
  assign head.head_data_valid = valid_q[1:0];
  // the incoming word is also offered to the aligner this cycle
  assign head.in_data         = rdata_i;
  assign head.in_push         = push_i;

  ////////////////////////////////////////////////////////////////////////////
  // fill then shift, so a bypassed word leaves on the same pop
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    logic placed;
    placed    = 1'b0;
    data_int  = data_q;
    valid_int = valid_q;
    for (int i = 0; i < FETCH_DEPTH; i++) begin
      if (push_i && !placed && !valid_q[i]) begin
        data_int[i]  = rdata_i;
        valid_int[i] = 1'b1;
        placed       = 1'b1;
      end
    end

    data_n  = data_int;
    valid_n = valid_int;
    if (head.pop) begin
      for (int i = 0; i < FETCH_DEPTH - 1; i++) begin
        data_n[i]  = data_int[i+1];
        valid_n[i] = valid_int[i+1];
      end
      data_n[FETCH_DEPTH-1]  = '0;
      valid_n[FETCH_DEPTH-1] = 1'b0;
    end
  end

  // branch drops every word, including one returning this cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (branch_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_n;
    end
  end

  always_ff @(posedge clk) begin
    data_q <= data_n;
  end

endmodule

//--- src/addr_queue.sv
// entry 0 is the output address, an empty queue keeps the head so req_i must stay up while fetching
module addr_queue (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                branch_i,
  input  prefetch_pkg::addr_t branch_addr_i,
  input  logic                push_i,
  input  logic                wait_gnt_i,
  output logic                ready_o,
  output prefetch_pkg::addr_t fetch_addr_o,
  fetch_head_if.addr_side     head
);
  import prefetch_pkg::*;

  addr_t [FETCH_DEPTH-1:0] addr_q, addr_int, addr_n;
  logic  [FETCH_DEPTH-1:0] valid_q, valid_int, valid_n;
  addr_t                   last_addr;

  assign ready_o              = !valid_q[FETCH_DEPTH-1];
  assign head.head_addr       = addr_q[1:0];
  assign head.head_addr_valid = valid_q[1:0];

  ////////////////////////////////////////////////////////////////////////////
  // next fetch address
  ////////////////////////////////////////////////////////////////////////////

  // newest address in the queue, head when nothing else is valid
  always_comb begin
    last_addr = addr_q[0];
    for (int i = 1; i < FETCH_DEPTH; i++) begin
      if (valid_q[i]) begin
        last_addr = addr_q[i];
      end
    end
  end

  // word after the newest one, or that word again while the grant is pending
  always_comb begin
    fetch_addr_o = last_addr & ~addr_t'(WORD_BYTES - 1);
    if (!wait_gnt_i) begin
      fetch_addr_o = fetch_addr_o + addr_t'(WORD_BYTES);
    end
    // redirect wins
    if (branch_i) begin
      fetch_addr_o = branch_addr_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // fill and advance
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    logic placed;
    placed    = 1'b0;
    addr_int  = addr_q;
    valid_int = valid_q;
    // first free slot takes the pushed address
    for (int i = 0; i < FETCH_DEPTH; i++) begin
      if (push_i && !placed && !valid_q[i]) begin
        addr_int[i]  = fetch_addr_o;
        valid_int[i] = 1'b1;
        placed       = 1'b1;
      end
    end

    addr_n  = addr_int;
    valid_n = valid_int;
    if (head.pop) begin
      for (int i = 0; i < FETCH_DEPTH - 1; i++) begin
        addr_n[i]  = addr_int[i+1];
        valid_n[i] = valid_int[i+1];
      end
      addr_n[FETCH_DEPTH-1]  = '0;
      valid_n[FETCH_DEPTH-1] = 1'b0;
      // new head starts at the halfword the aligner picked
      addr_n[0][1:0] = {head.next_half, 1'b0};
    end else if (head.half_step) begin
      addr_n[0] = addr_int[0] + addr_t'(HALF_BYTES);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (branch_i) begin
      valid_q <= {{(FETCH_DEPTH-1){1'b0}}, push_i};
    end else begin
      valid_q <= valid_n;
    end
  end

  // branch reloads the head with the target
  always_ff @(posedge clk) begin
    if (branch_i) begin
      addr_q[0] <= branch_addr_i;
    end else begin
      addr_q <= addr_n;
    end
  end

endmodule

//--- src/fetch_fsm.sv
// one access outstanding at a time, memory may take a changed address while the grant is pending
module fetch_fsm (
  input  logic clk,
  input  logic rst_n,
  input  logic req_i,
  input  logic branch_i,
  input  logic addr_ready_i,
  input  logic instr_gnt_i,
  input  logic instr_rvalid_i,
  output logic instr_req_o,
  output logic addr_push_o,
  output logic data_push_o,
  output logic wait_gnt_o,
  output logic busy_o
);
  import prefetch_pkg::*;

  prefetch_pkg::fetch_state_t state_q, state_n;
  logic start;

  // a new fetch is wanted: core asks with room left, or a branch redirects
  assign start = (req_i && addr_ready_i) || branch_i;

  // busy while anything is in flight or about to be
  assign busy_o = (state_q != idle) || instr_req_o;

  ////////////////////////////////////////////////////////////////////////////
  // next state and strobes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_n     = state_q;
    instr_req_o = 1'b0;
    addr_push_o = 1'b0;
    data_push_o = 1'b0;
    wait_gnt_o  = 1'b0;

    unique case (state_q)
      idle: begin
        if (start) begin
          instr_req_o = 1'b1;
          addr_push_o = 1'b1;
          state_n     = instr_gnt_i ? wait_rvalid : wait_gnt;
        end
      end

      // request is up, keep the address stable unless a branch replaces it
      wait_gnt: begin
        wait_gnt_o  = 1'b1;
        instr_req_o = 1'b1;
        addr_push_o = branch_i;
        if (instr_gnt_i) begin
          state_n = wait_rvalid;
        end
      end

      wait_rvalid: begin
        if (start) begin
          if (instr_rvalid_i) begin
            // data back, the next request goes out in the same cycle
            instr_req_o = 1'b1;
            addr_push_o = 1'b1;
            // returning word belongs to the old stream on a branch
            data_push_o = !branch_i;
            state_n     = instr_gnt_i ? wait_rvalid : wait_gnt;
          end else if (branch_i) begin
            // response still out, it has to be drained first
            addr_push_o = 1'b1;
            state_n     = wait_aborted;
          end
        end else if (instr_rvalid_i) begin
          data_push_o = 1'b1;
          state_n     = idle;
        end
      end

      // stale response pending, the branch target is already queued
      wait_aborted: begin
        wait_gnt_o  = 1'b1;
        addr_push_o = branch_i;
        if (instr_rvalid_i) begin
          instr_req_o = 1'b1;
          state_n     = instr_gnt_i ? wait_rvalid : wait_gnt;
        end
      end

      default: begin
        state_n = idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= idle;
    end else begin
      state_q <= state_n;
    end
  end

endmodule

//--- src/fetch_head_if.sv
// queue heads towards the aligner and the advance strobes back, entries 0 and 1 only
interface fetch_head_if;
  import prefetch_pkg::*;

  // address entries 0 and 1, from the address queue
  addr_t [1:0] head_addr;
  logic  [1:0] head_addr_valid;

  // data entries 0 and 1, from the data queue
  word_t [1:0] head_data;
  logic  [1:0] head_data_valid;

  // word returning from memory this cycle, for the bypass
  word_t       in_data;
  logic        in_push;

  // shift both queues by one entry
  logic        pop;
  // move the head address by one halfword, no shift
  logic        half_step;
  // halfword the new head starts at after a pop
  logic        next_half;

  modport addr_side (
    output head_addr, head_addr_valid,
    input  pop, half_step, next_half
  );

  modport data_side (
    output head_data, head_data_valid, in_data, in_push,
    input  pop
  );

  modport aligner (
    input  head_addr, head_addr_valid, head_data, head_data_valid,
    input  in_data, in_push,
    output pop, half_step, next_half
  );

endinterface

//--- src/prefetch_pkg.sv
// shared widths and constants for the prefetch buffer, queue depth must stay at least 2
package prefetch_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  // byte address of an instruction or fetched word
  typedef logic [31:0] addr_t;
  // memory word, also used for the output instruction
  typedef logic [31:0] word_t;
  // one compressed parcel
  typedef logic [15:0] half_t;

  ////////////////////////////////////////////////////////////////////////////
  // queue and instruction constants
  ////////////////////////////////////////////////////////////////////////////

  // entries in both the address and the data queue
  localparam int FETCH_DEPTH = 3;
  // step between consecutive fetched words
  localparam int WORD_BYTES = 4;
  // step over a compressed instruction
  localparam int HALF_BYTES = 2;
  // low opcode bits of a 32-bit instruction, anything else is compressed
  localparam logic [1:0] UNCOMPRESSED_OP = 2'b11;

  // memory-side fetch states
  typedef enum logic [1:0] {
    idle,
    wait_gnt,
    wait_rvalid,
    wait_aborted
  } fetch_state_t;

endpackage
